// File: design/exe_cfg.svh
// ------------------------------------------------
// Execute stage configuration
// Widths, unit select bits and multiplier length
// ------------------------------------------------
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

`define EXE_XLEN      32 // Data word width
`define EXE_UOP_W     5  // Micro-op width
`define EXE_FU_W      5  // One-hot unit vector width

`define EXE_FU_ALU    0  // Integer ALU
`define EXE_FU_MUL    1  // Multiplier
`define EXE_FU_LSU    2  // Load/store unit
`define EXE_FU_CFU    3  // Control flow unit
`define EXE_FU_CSR    4  // CSR access

`define EXE_LSU_LOAD  0  // Load bit of an LSU micro-op
`define EXE_LSU_STORE 1  // Store bit of an LSU micro-op

`define EXE_MUL_STEPS 32 // Shift-add iterations per multiply

`endif

// File: design/exe_pkg.sv
// ------------------------------------------------
// Execute stage types
// Data vectors, micro-op encodings, mul FSM states
// ------------------------------------------------
`include "exe_cfg.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0]   word_t;     // One data word
    typedef logic [2*`EXE_XLEN-1:0] dword_t;    // Full product
    typedef logic [`EXE_UOP_W-1:0]  uop_t;      // Micro-op
    typedef logic [`EXE_FU_W-1:0]   fu_t;       // One-hot unit select
    typedef logic [4:0]             reg_addr_t; // GPR address

    // ALU micro-ops
    typedef enum logic [`EXE_UOP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR,
        ALU_SLT, ALU_SLTU
    } alu_op_e;

    // Control flow micro-ops, conditional branches first
    typedef enum logic [`EXE_UOP_W-1:0] {
        CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU,
        CFU_JAL, CFU_JALR,
        CFU_TAKEN, CFU_NOT_TAKEN
    } cfu_op_e;

    // Multiply micro-ops
    typedef enum logic [`EXE_UOP_W-1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHU, MUL_MULHSU
    } mul_op_e;

    // Multiplier FSM
    typedef enum logic [1:0] {
        MUL_IDLE, MUL_RUN, MUL_DONE
    } mul_state_e;

endpackage

// File: design/exe_alu.sv
// ------------------------------------------------
// Integer ALU
// Logic, shift, rotate and compare in one cycle,
// plus a raw sum for address and JALR targets
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_alu (
    input  exe_pkg::uop_t  i_uop,     // ALU micro-op
    input  exe_pkg::word_t i_opr_a,   // Left operand
    input  exe_pkg::word_t i_opr_b,   // Right operand
    output exe_pkg::word_t o_result,  // Selected result
    output exe_pkg::word_t o_add_sum  // a + b for address generation
);

    exe_pkg::word_t sum;
    exe_pkg::word_t diff;
    exe_pkg::word_t ror;
    logic [4:0]     shamt;
    logic           lt_s;
    logic           lt_u;

    assign sum   = i_opr_a + i_opr_b;
    assign diff  = i_opr_a - i_opr_b;
    assign shamt = i_opr_b[4:0];                  // Low 5 bits only
    assign lt_s  = $signed(i_opr_a) < $signed(i_opr_b);
    assign lt_u  = i_opr_a < i_opr_b;

    // Zero shift leaves the left term alone, the right one drops out
    assign ror = (i_opr_a >> shamt) | (i_opr_a << (`EXE_XLEN - shamt));

    assign o_add_sum = sum;

    always_comb begin
        case (exe_pkg::alu_op_e'(i_uop))
            exe_pkg::ALU_ADD:  o_result = sum;
            exe_pkg::ALU_SUB:  o_result = diff;
            exe_pkg::ALU_XOR:  o_result = i_opr_a ^ i_opr_b;
            exe_pkg::ALU_OR:   o_result = i_opr_a | i_opr_b;
            exe_pkg::ALU_AND:  o_result = i_opr_a & i_opr_b;
            exe_pkg::ALU_SLL:  o_result = i_opr_a << shamt;
            exe_pkg::ALU_SRL:  o_result = i_opr_a >> shamt;
            exe_pkg::ALU_SRA:  o_result = $signed(i_opr_a) >>> shamt; // Sign fill
            exe_pkg::ALU_ROR:  o_result = ror;
            exe_pkg::ALU_SLT:  o_result = {{(`EXE_XLEN-1){1'b0}}, lt_s};
            exe_pkg::ALU_SLTU: o_result = {{(`EXE_XLEN-1){1'b0}}, lt_u};
            default:           o_result = '0;          // Unused encodings
        endcase
    end

endmodule

// File: design/exe_branch.sv
// ------------------------------------------------
// Branch resolution
// Rewrites conditional branches to taken/not
// taken and forms the jump target
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_branch (
    input  exe_pkg::uop_t  i_uop,     // CFU micro-op
    input  exe_pkg::word_t i_opr_a,   // Compare lhs
    input  exe_pkg::word_t i_opr_b,   // Compare rhs
    input  exe_pkg::word_t i_opr_c,   // Precomputed target
    input  exe_pkg::word_t i_add_sum, // rs1 + imm from the ALU
    output exe_pkg::uop_t  o_uop,     // Rewritten micro-op
    output exe_pkg::word_t o_target   // Jump target, bit 0 clear
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;   // Conditional branch op
    logic taken;

    assign eq   = i_opr_a == i_opr_b;
    assign lt_s = $signed(i_opr_a) < $signed(i_opr_b);
    assign lt_u = i_opr_a < i_opr_b;

    always_comb begin
        cond  = 1'b1;
        taken = 1'b0;
        case (exe_pkg::cfu_op_e'(i_uop))
            exe_pkg::CFU_BEQ:  taken = eq;
            exe_pkg::CFU_BNE:  taken = !eq;
            exe_pkg::CFU_BLT:  taken = lt_s;
            exe_pkg::CFU_BGE:  taken = !lt_s;
            exe_pkg::CFU_BLTU: taken = lt_u;
            exe_pkg::CFU_BGEU: taken = !lt_u;
            default:           cond  = 1'b0;  // Jumps pass unchanged
        endcase
    end

    assign o_uop = !cond ? i_uop :
                   taken ? exe_pkg::uop_t'(exe_pkg::CFU_TAKEN) :
                           exe_pkg::uop_t'(exe_pkg::CFU_NOT_TAKEN);

    assign o_target = (i_uop == exe_pkg::CFU_JALR) ? {i_add_sum[`EXE_XLEN-1:1], 1'b0} :
                                                     {i_opr_c[`EXE_XLEN-1:1], 1'b0};

endmodule

// File: design/exe_mul.sv
// ------------------------------------------------
// Iterative multiplier
// Shift-add over unsigned magnitudes, sign fixed
// at the end, low or high half selected by op
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_mul (
    input  logic           g_clk,
    input  logic           g_resetn,
    input  logic           i_start,   // Begin on a new multiply
    input  logic           i_abort,   // Flush or result consumed
    input  exe_pkg::uop_t  i_uop,     // MUL/MULH/MULHU/MULHSU
    input  exe_pkg::word_t i_opr_a,
    input  exe_pkg::word_t i_opr_b,
    output logic           o_ready,   // Product valid
    output exe_pkg::word_t o_result
);

    localparam int CNT_W = $clog2(`EXE_MUL_STEPS);

    exe_pkg::mul_state_e state;
    logic [CNT_W-1:0]    count;       // Steps done
    exe_pkg::dword_t     prod;        // {partial sum, remaining multiplier}
    exe_pkg::word_t      mcand;       // Multiplicand magnitude
    logic                neg;         // Product must be negated
    logic                hi_sel;      // Return the upper half
    logic                a_signed;
    logic                b_signed;
    logic                a_neg;
    logic                b_neg;
    logic [`EXE_XLEN:0]  step_sum;    // One carry bit wider
    exe_pkg::dword_t     full;

    assign a_signed = (i_uop == exe_pkg::MUL_MULH) || (i_uop == exe_pkg::MUL_MULHSU);
    assign b_signed = (i_uop == exe_pkg::MUL_MULH);
    assign a_neg    = a_signed && i_opr_a[`EXE_XLEN-1];
    assign b_neg    = b_signed && i_opr_b[`EXE_XLEN-1];

    // Add multiplicand when the current multiplier bit is set
    assign step_sum = {1'b0, prod[2*`EXE_XLEN-1:`EXE_XLEN]} + (prod[0] ? mcand : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_abort) begin
            state <= exe_pkg::MUL_IDLE;
            count <= '0;
        end else begin
            case (state)
                exe_pkg::MUL_IDLE: if (i_start) begin
                    state <= exe_pkg::MUL_RUN;
                    count <= '0;
                end
                exe_pkg::MUL_RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`EXE_MUL_STEPS - 1)) begin
                        state <= exe_pkg::MUL_DONE;         // Last step
                    end
                end
                default: state <= state;                 // DONE holds
            endcase
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (state == exe_pkg::MUL_IDLE && i_start) begin
            mcand  <= a_neg ? -i_opr_a : i_opr_a;
            prod   <= {{`EXE_XLEN{1'b0}}, (b_neg ? -i_opr_b : i_opr_b)};
            neg    <= a_neg ^ b_neg;
            hi_sel <= i_uop != exe_pkg::MUL_MUL;
        end else if (state == exe_pkg::MUL_RUN) begin
            prod   <= {step_sum, prod[`EXE_XLEN-1:1]};   // Shift right one
        end
    end

    assign full     = neg ? -prod : prod;
    assign o_ready  = state == exe_pkg::MUL_DONE;
    assign o_result = hi_sel ? full[2*`EXE_XLEN-1:`EXE_XLEN] : full[`EXE_XLEN-1:0];

endmodule

// File: design/exe_control.sv
// ------------------------------------------------
// Execute stage control
// Busy and progress, stage-valid register,
// multiplier start and operand load enables
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_control (
    input  logic          g_clk,
    input  logic          g_resetn,
    input  logic          i_s2_valid,   // Decode has an instruction
    input  exe_pkg::fu_t  i_s2_fu,
    input  exe_pkg::uop_t i_s2_uop,
    input  logic          i_flush,
    input  logic          i_s3_busy,    // Writeback stalls
    input  logic          i_mul_ready,  // Product available
    output logic          o_s2_busy,
    output logic          o_progress,   // Instruction moves into s3
    output logic          o_mul_start,
    output logic          o_opra_ld,
    output logic          o_oprb_ld,
    output logic          o_s3_valid
);

    logic s3_valid_q;
    logic held;        // s3 output held by back-pressure
    logic mul_pend;    // Multiply not finished
    logic store_op;

    assign held     = s3_valid_q && i_s3_busy;
    assign mul_pend = i_s2_valid && i_s2_fu[`EXE_FU_MUL] && !i_mul_ready;
    assign store_op = i_s2_fu[`EXE_FU_LSU] && i_s2_uop[`EXE_LSU_STORE];

    assign o_s2_busy   = held || mul_pend;
    assign o_progress  = i_s2_valid && !o_s2_busy;
    assign o_mul_start = mul_pend;   // Runs even while s3 is held

    // Operand b only carries store data or CSR write data
    assign o_opra_ld = o_progress;
    assign o_oprb_ld = o_progress && (store_op || i_s2_fu[`EXE_FU_CSR]);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            s3_valid_q <= 1'b0;
        end else if (o_progress) begin
            s3_valid_q <= 1'b1;             // New instruction in
        end else if (!i_s3_busy) begin
            s3_valid_q <= 1'b0;             // Consumed, nothing behind
        end
    end

    assign o_s3_valid = s3_valid_q;

endmodule

// File: design/exe_result_reg.sv
// ------------------------------------------------
// Result select and stage registers
// Picks the unit result, registers it into s3 and
// drives the early forwarding outputs
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_result_reg (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  exe_pkg::fu_t       i_fu,
    input  exe_pkg::uop_t      i_uop,
    input  exe_pkg::reg_addr_t i_rd,
    input  logic               i_trap,        // Passed through only
    input  exe_pkg::word_t     i_opr_a,       // CSR operand
    input  exe_pkg::word_t     i_opr_c,       // Store / CSR data
    input  exe_pkg::word_t     i_alu_result,
    input  exe_pkg::word_t     i_add_sum,     // Load/store address
    input  exe_pkg::word_t     i_target,      // Jump target
    input  exe_pkg::word_t     i_mul_result,
    input  exe_pkg::uop_t      i_cfu_uop,     // Resolved branch op
    input  logic               i_opra_ld,
    input  logic               i_oprb_ld,
    input  logic               i_progress,
    output exe_pkg::reg_addr_t o_s3_rd,
    output exe_pkg::uop_t      o_s3_uop,
    output exe_pkg::fu_t       o_s3_fu,
    output logic               o_s3_trap,
    output exe_pkg::word_t     o_s3_opr_a,
    output exe_pkg::word_t     o_s3_opr_b,
    output exe_pkg::reg_addr_t o_fwd_rd,
    output exe_pkg::word_t     o_fwd_wdata,
    output logic               o_fwd_load
);

    exe_pkg::word_t n_opr_a;
    exe_pkg::uop_t  n_uop;

    // ------------------------------------------------
    // Next-state selection
    // ------------------------------------------------
    // One-hot unit vector, so an AND-OR mux is enough
    assign n_opr_a = ({`EXE_XLEN{i_fu[`EXE_FU_ALU]}} & i_alu_result) |
                     ({`EXE_XLEN{i_fu[`EXE_FU_MUL]}} & i_mul_result) |
                     ({`EXE_XLEN{i_fu[`EXE_FU_LSU]}} & i_add_sum)    |
                     ({`EXE_XLEN{i_fu[`EXE_FU_CFU]}} & i_target)     |
                     ({`EXE_XLEN{i_fu[`EXE_FU_CSR]}} & i_opr_a);

    assign n_uop = i_fu[`EXE_FU_CFU] ? i_cfu_uop : i_uop;   // Branch outcome

    // ------------------------------------------------
    // Stage registers
    // ------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_s3_rd   <= '0;
            o_s3_uop  <= '0;
            o_s3_fu   <= '0;
            o_s3_trap <= 1'b0;
        end else if (i_progress) begin
            o_s3_rd   <= i_rd;
            o_s3_uop  <= n_uop;
            o_s3_fu   <= i_fu;
            o_s3_trap <= i_trap;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_s3_opr_a <= '0;
            o_s3_opr_b <= '0;
        end else begin
            if (i_opra_ld) begin
                o_s3_opr_a <= n_opr_a;
            end
            if (i_oprb_ld) begin
                o_s3_opr_b <= i_opr_c;   // Otherwise keeps last value
            end
        end
    end

    // Early forwarding, combinational from s2
    assign o_fwd_rd    = i_rd;
    assign o_fwd_wdata = n_opr_a;
    assign o_fwd_load  = i_fu[`EXE_FU_LSU] && i_uop[`EXE_LSU_LOAD];

endmodule

// File: design/exe_stage.sv
// ------------------------------------------------
// Execute stage top level
// Connects control, ALU, branch unit, multiplier
// and the s3 result registers
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_stage (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 i_s2_valid,
    input  logic [`EXE_FU_W-1:0] i_s2_fu,
    input  logic [`EXE_UOP_W-1:0] i_s2_uop,
    input  logic [4:0]           i_s2_rd,
    input  logic                 i_s2_trap,
    input  logic [`EXE_XLEN-1:0] i_s2_opr_a,
    input  logic [`EXE_XLEN-1:0] i_s2_opr_b,
    input  logic [`EXE_XLEN-1:0] i_s2_opr_c,
    input  logic                 i_flush,
    input  logic                 i_s3_busy,
    output logic                 o_s2_busy,
    output logic                 o_s3_valid,
    output logic [4:0]           o_s3_rd,
    output logic [`EXE_UOP_W-1:0] o_s3_uop,
    output logic [`EXE_FU_W-1:0] o_s3_fu,
    output logic                 o_s3_trap,
    output logic [`EXE_XLEN-1:0] o_s3_opr_a,
    output logic [`EXE_XLEN-1:0] o_s3_opr_b,
    output logic [4:0]           o_fwd_rd,
    output logic [`EXE_XLEN-1:0] o_fwd_wdata,
    output logic                 o_fwd_load
);

    logic                  progress;
    logic                  mul_start;
    logic                  mul_ready;
    logic                  opra_ld;
    logic                  oprb_ld;
    logic [`EXE_XLEN-1:0]  alu_result;
    logic [`EXE_XLEN-1:0]  add_sum;
    logic [`EXE_XLEN-1:0]  target;
    logic [`EXE_XLEN-1:0]  mul_result;
    logic [`EXE_UOP_W-1:0] cfu_uop;

    exe_control u_control (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_s2_valid(i_s2_valid), .i_s2_fu(i_s2_fu), .i_s2_uop(i_s2_uop),
        .i_flush(i_flush), .i_s3_busy(i_s3_busy), .i_mul_ready(mul_ready),
        .o_s2_busy(o_s2_busy), .o_progress(progress), .o_mul_start(mul_start),
        .o_opra_ld(opra_ld), .o_oprb_ld(oprb_ld), .o_s3_valid(o_s3_valid)
    );

    exe_alu u_alu (
        .i_uop(i_s2_uop), .i_opr_a(i_s2_opr_a), .i_opr_b(i_s2_opr_b),
        .o_result(alu_result), .o_add_sum(add_sum)
    );

    exe_branch u_branch (
        .i_uop(i_s2_uop), .i_opr_a(i_s2_opr_a), .i_opr_b(i_s2_opr_b),
        .i_opr_c(i_s2_opr_c), .i_add_sum(add_sum),
        .o_uop(cfu_uop), .o_target(target)
    );

    // Product consumed on progress, dropped on flush
    exe_mul u_mul (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_start(mul_start), .i_abort(i_flush || progress),
        .i_uop(i_s2_uop), .i_opr_a(i_s2_opr_a), .i_opr_b(i_s2_opr_b),
        .o_ready(mul_ready), .o_result(mul_result)
    );

    exe_result_reg u_result (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_fu(i_s2_fu), .i_uop(i_s2_uop), .i_rd(i_s2_rd), .i_trap(i_s2_trap),
        .i_opr_a(i_s2_opr_a), .i_opr_c(i_s2_opr_c),
        .i_alu_result(alu_result), .i_add_sum(add_sum), .i_target(target),
        .i_mul_result(mul_result), .i_cfu_uop(cfu_uop),
        .i_opra_ld(opra_ld), .i_oprb_ld(oprb_ld), .i_progress(progress),
        .o_s3_rd(o_s3_rd), .o_s3_uop(o_s3_uop), .o_s3_fu(o_s3_fu),
        .o_s3_trap(o_s3_trap), .o_s3_opr_a(o_s3_opr_a), .o_s3_opr_b(o_s3_opr_b),
        .o_fwd_rd(o_fwd_rd), .o_fwd_wdata(o_fwd_wdata), .o_fwd_load(o_fwd_load)
    );

endmodule

// File: test/tb_exe_stage.sv
// ------------------------------------------------
// Execute stage testbench
// Random ALU, branch, load/store, CSR and multiply
// traffic checked against a reference model
// ------------------------------------------------
`timescale 1ns/1ps
`include "exe_cfg.svh"

module tb_exe_stage;

    localparam int TIMEOUT = 500;          // Cycles allowed per wait

    logic               g_clk;
    logic               g_resetn;
    logic               i_s2_valid;
    exe_pkg::fu_t       i_s2_fu;
    exe_pkg::uop_t      i_s2_uop;
    exe_pkg::reg_addr_t i_s2_rd;
    logic               i_s2_trap;
    exe_pkg::word_t     i_s2_opr_a;
    exe_pkg::word_t     i_s2_opr_b;
    exe_pkg::word_t     i_s2_opr_c;
    logic               i_flush;
    logic               i_s3_busy;
    logic               o_s2_busy;
    logic               o_s3_valid;
    exe_pkg::reg_addr_t o_s3_rd;
    exe_pkg::uop_t      o_s3_uop;
    exe_pkg::fu_t       o_s3_fu;
    logic               o_s3_trap;
    exe_pkg::word_t     o_s3_opr_a;
    exe_pkg::word_t     o_s3_opr_b;
    exe_pkg::reg_addr_t o_fwd_rd;
    exe_pkg::word_t     o_fwd_wdata;
    logic               o_fwd_load;

    logic [15:0]        lfsr;              // Stimulus stream
    logic [15:0]        bp_lfsr;           // Back-pressure stream
    logic               bp_on;             // Random i_s3_busy enabled
    exe_pkg::word_t     last_b;            // Model of the s3 operand b register
    exe_pkg::word_t     exp_a_q[$];
    exe_pkg::word_t     exp_b_q[$];
    exe_pkg::uop_t      exp_uop_q[$];
    exe_pkg::reg_addr_t exp_rd_q[$];
    exe_pkg::fu_t       exp_fu_q[$];
    logic               exp_trap_q[$];
    int                 err_count;
    int                 n_checks;
    int                 n_issued;
    int                 t_err;             // Error count at test start
    int                 t_n;               // Issue count at test start

    exe_stage uut (.*);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;         // 100 MHz
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output exe_pkg::word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};     // One step per bit
        end
    endtask

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    function automatic void exe_ref(
        input  exe_pkg::fu_t   fu,
        input  exe_pkg::uop_t  uop,
        input  exe_pkg::word_t a,
        input  exe_pkg::word_t b,
        input  exe_pkg::word_t c,
        input  exe_pkg::word_t prev_b,
        output exe_pkg::word_t ea,
        output exe_pkg::word_t eb,
        output exe_pkg::uop_t  eu
    );
        logic [4:0]  sh;
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] wide;
        logic        taken;
        sh    = b[4:0];
        ea    = '0;
        eb    = prev_b;                    // Held unless reloaded
        eu    = uop;
        taken = 1'b0;
        if (fu[`EXE_FU_ALU]) begin
            case (uop)
                exe_pkg::ALU_ADD:  ea = a + b;
                exe_pkg::ALU_SUB:  ea = a + ~b + 32'd1;
                exe_pkg::ALU_XOR:  ea = a ^ b;
                exe_pkg::ALU_OR:   ea = a | b;
                exe_pkg::ALU_AND:  ea = a & b;
                exe_pkg::ALU_SLL:  ea = a << sh;
                exe_pkg::ALU_SRL:  ea = a >> sh;
                exe_pkg::ALU_SRA:  ea = exe_pkg::word_t'({{32{a[31]}}, a} >> sh);
                exe_pkg::ALU_ROR:  ea = exe_pkg::word_t'({a, a} >> sh);
                exe_pkg::ALU_SLT:  ea = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
                exe_pkg::ALU_SLTU: ea = {31'b0, a < b};
                default:           ea = '0;
            endcase
        end else if (fu[`EXE_FU_MUL]) begin
            xa   = (uop == exe_pkg::MUL_MULH || uop == exe_pkg::MUL_MULHSU) ?
                   {{32{a[31]}}, a} : {32'b0, a};
            xb   = (uop == exe_pkg::MUL_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
            wide = xa * xb;                // Exact modulo 2^64
            ea   = (uop == exe_pkg::MUL_MUL) ? wide[31:0] : wide[63:32];
        end else if (fu[`EXE_FU_LSU]) begin
            ea = a + b;                    // Effective address
            if (uop[`EXE_LSU_STORE]) eb = c;
        end else if (fu[`EXE_FU_CFU]) begin
            case (uop)
                exe_pkg::CFU_BEQ:  taken = a == b;
                exe_pkg::CFU_BNE:  taken = a != b;
                exe_pkg::CFU_BLT:  taken = $signed(a) < $signed(b);
                exe_pkg::CFU_BGE:  taken = $signed(a) >= $signed(b);
                exe_pkg::CFU_BLTU: taken = a < b;
                exe_pkg::CFU_BGEU: taken = a >= b;
                default:           taken = 1'b0;
            endcase
            if (uop <= exe_pkg::CFU_BGEU) begin
                eu = taken ? exe_pkg::CFU_TAKEN : exe_pkg::CFU_NOT_TAKEN;
            end
            ea = (uop == exe_pkg::CFU_JALR) ? ((a + b) & ~32'h1) : (c & ~32'h1);
        end else if (fu[`EXE_FU_CSR]) begin
            ea = a;
            eb = c;                        // CSR write data
        end
    endfunction

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------
    task automatic check_word(input exe_pkg::word_t got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_uop(input exe_pkg::uop_t got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input exe_pkg::reg_addr_t got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_fu(input exe_pkg::fu_t got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s is %05b, expected %05b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    task automatic issue(input int unit, input exe_pkg::uop_t uop,
                         input exe_pkg::word_t a, b, c, input logic trap);
        exe_pkg::fu_t       fu;
        exe_pkg::reg_addr_t rd;
        exe_pkg::word_t     ea;
        exe_pkg::word_t     eb;
        exe_pkg::uop_t      eu;
        int                 waited;
        fu = exe_pkg::fu_t'(1 << unit);
        rd = exe_pkg::reg_addr_t'(n_issued);
        exe_ref(fu, uop, a, b, c, last_b, ea, eb, eu);
        @(posedge g_clk);
        #1;
        i_s2_valid = 1'b1;
        i_s2_fu    = fu;
        i_s2_uop   = uop;
        i_s2_rd    = rd;
        i_s2_trap  = trap;
        i_s2_opr_a = a;
        i_s2_opr_b = b;
        i_s2_opr_c = c;
        @(negedge g_clk);
        if (fu[`EXE_FU_MUL]) check_bit(o_s2_busy, 1'b1, "busy on multiply");
        waited = 0;
        while (o_s2_busy) begin            // Upstream holds its inputs
            waited++;
            if (waited > TIMEOUT) fail_timeout("the stage to accept an instruction");
            @(negedge g_clk);
        end
        check_bit(o_fwd_load, fu[`EXE_FU_LSU] && uop[`EXE_LSU_LOAD], "forwarded load flag");
        check_rd(o_fwd_rd, rd, "forwarded rd");
        check_word(o_fwd_wdata, ea, "forwarded write data");
        #1;                                // Push after the compare process
        last_b = eb;
        exp_a_q.push_back(ea);
        exp_b_q.push_back(eb);
        exp_uop_q.push_back(eu);
        exp_rd_q.push_back(rd);
        exp_fu_q.push_back(fu);
        exp_trap_q.push_back(trap);
        n_issued++;
    endtask

    task automatic issue_op(input int unit, input exe_pkg::uop_t uop);
        exe_pkg::word_t a;
        exe_pkg::word_t b;
        exe_pkg::word_t c;
        exe_pkg::word_t r;
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(32, c);
        rand_bits(2, r);
        if (unit == `EXE_FU_CFU && r[0]) b = a;   // Equal operands half the time
        issue(unit, uop, a, b, c, r[1]);
    endtask

    task automatic issue_random(input int unit);
        exe_pkg::word_t r;
        exe_pkg::uop_t  uop;
        case (unit)
            `EXE_FU_ALU: rand_bits(4, r);
            `EXE_FU_MUL: rand_bits(2, r);
            `EXE_FU_LSU: rand_bits(1, r);
            `EXE_FU_CFU: rand_bits(3, r);
            default:     rand_bits(5, r);
        endcase
        uop = exe_pkg::uop_t'(r);
        if (unit == `EXE_FU_ALU) uop = exe_pkg::uop_t'(r % 11);
        if (unit == `EXE_FU_LSU) uop = r[0] ? 5'b00010 : 5'b00001;   // Store or load
        issue_op(unit, uop);
    endtask

    task automatic idle_inputs();
        @(posedge g_clk);
        #1;
        i_s2_valid = 1'b0;
        i_s2_fu    = '0;
        i_s2_uop   = '0;
    endtask

    task automatic wait_drain();
        int waited;
        idle_inputs();
        waited = 0;
        do begin
            waited++;
            if (waited > TIMEOUT) fail_timeout("the s3 outputs to drain");
            @(negedge g_clk);
            check_bit(o_fwd_load, 1'b0, "forwarded load flag while idle");
            #1;
        end while (exp_a_q.size() != 0);
    endtask

    task automatic report_test(input string name);
        $display("Test %-18s %0d instructions, %0d errors", name, n_issued - t_n,
                 err_count - t_err);
        t_n   = n_issued;
        t_err = err_count;
    endtask

    // Random back-pressure from writeback
    initial begin
        bp_lfsr   = 16'd6862;
        i_s3_busy = 1'b0;
        forever begin
            @(posedge g_clk);
            #1;
            bp_lfsr   = lfsr_step(bp_lfsr);
            i_s3_busy = bp_on && bp_lfsr[0];
        end
    end

    // Compare every instruction that leaves the stage
    initial begin
        forever begin
            @(negedge g_clk);
            if (g_resetn && o_s3_valid && !i_s3_busy) begin
                if (exp_a_q.size() == 0) begin
                    err_count++;
                    $display("Instruction on the s3 outputs at %0t ns that was never issued",
                             $time);
                end else begin
                    check_word(o_s3_opr_a, exp_a_q.pop_front(), "s3 operand a");
                    check_word(o_s3_opr_b, exp_b_q.pop_front(), "s3 operand b");
                    check_uop(o_s3_uop, exp_uop_q.pop_front(), "s3 micro-op");
                    check_rd(o_s3_rd, exp_rd_q.pop_front(), "s3 rd");
                    check_fu(o_s3_fu, exp_fu_q.pop_front(), "s3 unit");
                    check_bit(o_s3_trap, exp_trap_q.pop_front(), "s3 trap");
                end
            end
        end
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        g_resetn   = 1'b0;
        i_s2_valid = 1'b0;
        i_s2_fu    = '0;
        i_s2_uop   = '0;
        i_s2_rd    = '0;
        i_s2_trap  = 1'b0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_flush    = 1'b0;
        lfsr       = 16'd6862;
        bp_on      = 1'b0;
        last_b     = '0;
        err_count  = 0;
        n_checks   = 0;
        n_issued   = 0;
        t_err      = 0;
        t_n        = 0;
        repeat (4) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_bit(o_s3_valid, 1'b0, "s3 valid after reset");
        check_bit(o_s2_busy, 1'b0, "s2 busy after reset");
        check_word(o_s3_opr_a, '0, "s3 operand a after reset");
        check_word(o_s3_opr_b, '0, "s3 operand b after reset");
        report_test("reset state");

        for (int op = 0; op < 11; op++) repeat (4) issue_op(`EXE_FU_ALU, exe_pkg::uop_t'(op));
        wait_drain();
        report_test("alu ops");

        for (int op = 0; op < 8; op++) repeat (4) issue_op(`EXE_FU_CFU, exe_pkg::uop_t'(op));
        wait_drain();
        report_test("branch and jump");

        for (int i = 0; i < 30; i++) begin
            case (i % 3)                   // Loads, stores and CSR around ALU ops
                0:       issue_random(`EXE_FU_LSU);
                1:       issue_random((i % 2) ? `EXE_FU_CSR : `EXE_FU_ALU);
                default: issue_random(`EXE_FU_LSU);
            endcase
        end
        wait_drain();
        report_test("load store csr");

        for (int op = 0; op < 4; op++) repeat (3) issue_op(`EXE_FU_MUL, exe_pkg::uop_t'(op));
        wait_drain();
        report_test("multiply");

        bp_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            exe_pkg::word_t r;
            rand_bits(3, r);
            issue_random(int'(r % 5));
        end
        wait_drain();
        bp_on = 1'b0;
        report_test("back-pressure");

        // Multiply dropped by a flush part way through
        @(posedge g_clk);
        #1;
        i_s2_valid = 1'b1;
        i_s2_fu    = exe_pkg::fu_t'(1 << `EXE_FU_MUL);
        i_s2_uop   = exe_pkg::MUL_MULH;
        i_s2_opr_a = 32'h8765_4321;
        i_s2_opr_b = 32'h1234_5678;
        repeat (10) @(posedge g_clk);
        #1;
        i_flush    = 1'b1;
        i_s2_valid = 1'b0;
        i_s2_fu    = '0;
        @(posedge g_clk);
        #1;
        i_flush = 1'b0;
        repeat (40) begin
            @(negedge g_clk);
            check_bit(o_s3_valid, 1'b0, "s3 valid after flush");
        end
        issue_random(`EXE_FU_MUL);
        issue_random(`EXE_FU_ALU);
        wait_drain();
        report_test("flush");

        $display("Checks: %0d, errors: %0d, instructions: %0d", n_checks, err_count, n_issued);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/exe_pkg.sv
design/exe_alu.sv
design/exe_branch.sv
design/exe_mul.sv
design/exe_control.sv
design/exe_result_reg.sv
design/exe_stage.sv
test/tb_exe_stage.sv

// File: Makefile
# Verilator simulation of the execute stage
TOP = tb_exe_stage

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
